//--- risc_controller.f
+incdir+.
ctrl_pkg.sv
instr_decoder.sv
state_sequencer.sv
control_word_gen.sv
risc_controller.sv
ctrl_checker.sv
risc_controller_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the controller testbench with verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=risc_controller_sim

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module risc_controller_tb -f risc_controller.f -o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

//--- risc_controller_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_settings.svh"

module risc_controller_tb import ctrl_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 3;
	localparam int N_DIRECTED   = 32;   // uncond 8, cond 16, beq 4, mem 4
	localparam int N_RANDOM     = 300;
	localparam int N_TOTAL      = N_DIRECTED + N_RANDOM;
	localparam int WATCHDOG_NS  = N_TOTAL * 5 * CLK_PERIOD + 20 * CLK_PERIOD;  // worst case 5/instr

	localparam logic [2:0] T_UNCOND = 3'd1;
	localparam logic [2:0] T_COND   = 3'd2;
	localparam logic [2:0] T_BEQ    = 3'd3;
	localparam logic [2:0] T_MEM    = 3'd4;
	localparam logic [2:0] T_RANDOM = 3'd5;

	typedef struct packed {
		logic [3:0] cycles;  // fetch to fetch, fetch included
		logic [3:0] reg_w;
		logic [3:0] ccr;
		logic [3:0] mem_w;
	} profile_t;

	logic                clk = 1'b0;
	logic                reset;
	logic [`INSTR_W-1:0] instr_word;  // ir value seen by dut
	logic                carry;
	logic                zero;
	logic                exp_push;
	logic [2:0]          exp_test;
	logic [3:0]          exp_cycles;
	logic [3:0]          exp_reg_w;
	logic [3:0]          exp_ccr;
	logic [3:0]          exp_mem_w;
	ctrl_state_e         state;
	logic                mem_read, mem_write, reg_write, ir_write, ccr_update, alu_src_a;
	pc_src_e             pc_src;
	alu_b_src_e          alu_b_src;
	reg_dst_e            reg_dst;
	wb_src_e             wb_src;
	addr_src_e           addr_src;
	flag_src_e           flag_src;
	alu_op_e             alu_op;
	wire [31:0]          mismatch_cnt, protocol_cnt, checked_cnt;
	int                  seed      = 32'hcb44;
	int                  sent_cnt  = 0;
	int                  tb_errors = 0;

	risc_controller risc_controller_i (
		.clk (clk), .reset (reset), .i_instr (instr_word), .i_carry (carry), .i_zero (zero),
		.o_state (state), .o_mem_read (mem_read), .o_mem_write (mem_write),
		.o_reg_write (reg_write), .o_ir_write (ir_write), .o_ccr_update (ccr_update),
		.o_alu_src_a (alu_src_a), .o_pc_src (pc_src), .o_alu_b_src (alu_b_src),
		.o_reg_dst (reg_dst), .o_wb_src (wb_src), .o_addr_src (addr_src),
		.o_flag_src (flag_src), .o_alu_op (alu_op)
	);

	ctrl_checker ctrl_checker_i (
		.clk (clk), .reset (reset), .i_state (state), .i_ir_write (ir_write),
		.i_reg_write (reg_write), .i_ccr_update (ccr_update), .i_mem_write (mem_write),
		.i_mem_read (mem_read), .i_alu_src_a (alu_src_a), .i_pc_src (pc_src),
		.i_alu_b_src (alu_b_src), .i_reg_dst (reg_dst), .i_wb_src (wb_src),
		.i_addr_src (addr_src), .i_flag_src (flag_src), .i_alu_op (alu_op),
		.i_exp_push (exp_push), .i_exp_test (exp_test),
		.i_exp_cycles (exp_cycles), .i_exp_reg_w (exp_reg_w), .i_exp_ccr (exp_ccr),
		.i_exp_mem_w (exp_mem_w), .o_mismatch_cnt (mismatch_cnt),
		.o_protocol_cnt (protocol_cnt), .o_checked_cnt (checked_cnt)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==========================================================
	// reference model, cycle table per instruction
	// ==========================================================
	function automatic profile_t profile_of(input int cyc, input int rw, input int cu, input int mw);
		profile_t p;
		p.cycles = 4'(cyc);
		p.reg_w  = 4'(rw);
		p.ccr    = 4'(cu);
		p.mem_w  = 4'(mw);
		return p;
	endfunction

	function automatic profile_t expected_profile(input logic [`INSTR_W-1:0] word,
		input logic c, input logic z);
		instr_u iw;
		logic   runs;  // condition field allows the alu op
		iw = word;
		case (iw.r_fields.cz)
			2'b00:   runs = 1'b1;
			2'b10:   runs = c;  // adc ndc
			2'b01:   runs = z;  // adz ndz
			default: runs = 1'b0;
		endcase
		case (iw.r_fields.opcode)
			OP_ADD:  return runs ? profile_of(4, 2, 1, 0) : profile_of(2, 1, 0, 0);
			OP_NDU:  return runs ? profile_of(3, 2, 0, 0) : profile_of(2, 1, 0, 0);
			OP_ADI:  return profile_of(3, 2, 1, 0);
			OP_LHI:  return profile_of(3, 2, 0, 0);
			OP_LW:   return profile_of(4, 2, 1, 0);
			OP_SW:   return profile_of(4, 1, 0, 1);  // the only memory write
			OP_BEQ:  return z ? profile_of(5, 2, 1, 0) : profile_of(4, 1, 1, 0);
			OP_JAL, OP_JLR: return profile_of(4, 3, 0, 0);  // pc, link, target
			default: return profile_of(2, 1, 0, 0);  // unknown refetches
		endcase
	endfunction

	// ==========================================================
	// stimulus helpers
	// ==========================================================
	task automatic wait_fetch();
		@(posedge clk);
		while (ir_write !== 1'b1) begin
			@(posedge clk);
		end
	endtask

	task automatic issue_instr(input logic [`INSTR_W-1:0] word, input logic c, input logic z,
		input logic [2:0] test_id);
		profile_t p;
		wait_fetch();  // new word right after fetch
		p = expected_profile(word, c, z);
		instr_word <= word;  // held until next fetch
		carry      <= c;
		zero       <= z;
		exp_test   <= test_id;
		exp_cycles <= p.cycles;
		exp_reg_w  <= p.reg_w;
		exp_ccr    <= p.ccr;
		exp_mem_w  <= p.mem_w;
		exp_push   <= 1'b1;
		@(posedge clk);
		exp_push   <= 1'b0;
		sent_cnt++;
	endtask

	task automatic issue_op(input opcode_e op, input logic [1:0] low, input logic c,
		input logic z, input logic [2:0] test_id);
		logic [31:0] rnd;
		rnd = $random(seed);  // random register and immediate bits
		issue_instr({op, rnd[9:0], low}, c, z, test_id);
	endtask

	// ==========================================================
	// test sequence
	// ==========================================================
	initial begin : stimulus
		int          i;
		logic [31:0] rnd;
		reset      = 1'b0;
		instr_word = '0;
		carry      = 1'b0;
		zero       = 1'b0;
		exp_push   = 1'b0;
		exp_test   = 3'd0;
		exp_cycles = 4'd0;
		exp_reg_w  = 4'd0;
		exp_ccr    = 4'd0;
		exp_mem_w  = 4'd0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b1;
		issue_op(OP_ADD, 2'b00, 1'b0, 1'b0, T_UNCOND);
		issue_op(OP_NDU, 2'b00, 1'b1, 1'b0, T_UNCOND);
		issue_op(OP_ADI, 2'b11, 1'b0, 1'b1, T_UNCOND);  // low bits are imm here
		issue_op(OP_LHI, 2'b10, 1'b0, 1'b0, T_UNCOND);
		issue_op(OP_LW, 2'b01, 1'b1, 1'b1, T_UNCOND);
		issue_op(OP_SW, 2'b00, 1'b0, 1'b0, T_UNCOND);
		issue_op(OP_JAL, 2'b11, 1'b1, 1'b0, T_UNCOND);
		issue_op(OP_JLR, 2'b00, 1'b0, 1'b1, T_UNCOND);
		for (i = 0; i < 16; i++) begin  // adc ndc adz ndz over random flags
			rnd = $random(seed);
			issue_op(i[0] ? OP_NDU : OP_ADD, i[1] ? 2'b01 : 2'b10, rnd[0], rnd[1], T_COND);
		end
		issue_op(OP_BEQ, 2'b00, 1'b0, 1'b1, T_BEQ);  // taken
		issue_op(OP_BEQ, 2'b00, 1'b0, 1'b0, T_BEQ);
		issue_op(OP_BEQ, 2'b01, 1'b1, 1'b1, T_BEQ);
		issue_op(OP_BEQ, 2'b10, 1'b1, 1'b0, T_BEQ);
		issue_op(OP_SW, 2'b01, 1'b0, 1'b0, T_MEM);
		issue_op(OP_LW, 2'b10, 1'b0, 1'b0, T_MEM);
		issue_op(OP_SW, 2'b11, 1'b1, 1'b1, T_MEM);  // back to back store
		issue_op(OP_SW, 2'b00, 1'b0, 1'b1, T_MEM);
		for (i = 0; i < N_RANDOM; i++) begin  // unknown opcodes included
			rnd = $random(seed);
			issue_instr(rnd[15:0], rnd[16], rnd[17], T_RANDOM);
		end
		wait_fetch();  // closes the last window
		@(negedge clk);
		if (int'(checked_cnt) != sent_cnt) begin
			$display("only %0d of %0d instruction profiles were checked", checked_cnt, sent_cnt);
			tb_errors++;
		end
		$display("errors: %0d mismatch, %0d protocol, %0d testbench; %0d instructions checked",
			mismatch_cnt, protocol_cnt, tb_errors, checked_cnt);
		if (mismatch_cnt == 0 && protocol_cnt == 0 && tb_errors == 0) begin
			$display("Test completed successfully");
		end
		else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired, the controller stopped fetching after %0d of %0d instructions",
			sent_cnt, N_TOTAL);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- ctrl_checker.sv
`timescale 1ns/1ns
`default_nettype none

module ctrl_checker import ctrl_pkg::*; (
	input  wire              clk,
	input  wire              reset,           // sync, active low
	input  wire ctrl_state_e i_state,         // current fsm state
	input  wire              i_ir_write,      // fetch marker
	input  wire              i_reg_write,
	input  wire              i_ccr_update,
	input  wire              i_mem_write,
	input  wire              i_mem_read,
	input  wire              i_alu_src_a,
	input  wire pc_src_e     i_pc_src,
	input  wire alu_b_src_e  i_alu_b_src,
	input  wire reg_dst_e    i_reg_dst,
	input  wire wb_src_e     i_wb_src,
	input  wire addr_src_e   i_addr_src,
	input  wire flag_src_e   i_flag_src,
	input  wire alu_op_e     i_alu_op,
	input  wire              i_exp_push,      // one cycle strobe
	input  wire [2:0]        i_exp_test,      // test group id
	input  wire [3:0]        i_exp_cycles,
	input  wire [3:0]        i_exp_reg_w,
	input  wire [3:0]        i_exp_ccr,
	input  wire [3:0]        i_exp_mem_w,
	output wire [31:0]       o_mismatch_cnt,
	output wire [31:0]       o_protocol_cnt,
	output wire [31:0]       o_checked_cnt
);

	typedef struct packed {
		logic [2:0] test;
		logic [3:0] cycles;
		logic [3:0] reg_w;
		logic [3:0] ccr;
		logic [3:0] mem_w;
	} exp_entry_t;

	exp_entry_t exp_q[$];          // profiles waiting for their next fetch
	int  mismatch_cnt = 0;
	int  protocol_cnt = 0;
	int  checked_cnt  = 0;
	int  reset_cycles = 0;         // edges sampled with reset low
	int  since_reset  = 0;         // edges since release, saturates at 3
	bit  active       = 1'b0;      // an instruction is being counted
	int  cur_cycles   = 0;
	int  cur_reg_w    = 0;
	int  cur_ccr      = 0;
	int  cur_mem_w    = 0;
	logic [4:0] enables;

	assign enables        = {i_mem_read, i_mem_write, i_reg_write, i_ir_write, i_ccr_update};
	assign o_mismatch_cnt = mismatch_cnt;
	assign o_protocol_cnt = protocol_cnt;
	assign o_checked_cnt  = checked_cnt;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1:    test_name = "uncond_instr";
			3'd2:    test_name = "cond_alu";
			3'd3:    test_name = "beq";
			3'd4:    test_name = "mem_write";
			3'd5:    test_name = "random_stream";
			default: test_name = "unknown_test";
		endcase
	endfunction

	task automatic compare_field(input string test, input int idx, input string field,
		input int expected, input int actual);
		if (expected != actual) begin
			$display("Mismatch %s instr %0d %s: expected %0d, actual %0d",
				test, idx, field, expected, actual);
			mismatch_cnt++;
		end
	endtask

	// ==========================================================
	// fetch word, instruction from pc and pc plus one into r7
	// ==========================================================
	task automatic check_fetch_word();
		compare_field("fetch_word", checked_cnt, "mem_read", 1, int'(i_mem_read));
		compare_field("fetch_word", checked_cnt, "mem_write", 0, int'(i_mem_write));
		compare_field("fetch_word", checked_cnt, "ccr_update", 0, int'(i_ccr_update));
		compare_field("fetch_word", checked_cnt, "alu_src_a", 1, int'(i_alu_src_a));  // pc
		compare_field("fetch_word", checked_cnt, "pc_src", PC_SRC_ALU, i_pc_src);
		compare_field("fetch_word", checked_cnt, "alu_b_src", ALU_B_ONE, i_alu_b_src);
		compare_field("fetch_word", checked_cnt, "reg_dst", REG_DST_PC, i_reg_dst);
		compare_field("fetch_word", checked_cnt, "wb_src", WB_ALU, i_wb_src);
		compare_field("fetch_word", checked_cnt, "addr_src", ADDR_PC, i_addr_src);
		compare_field("fetch_word", checked_cnt, "flag_src", FLAG_NONE, i_flag_src);
		compare_field("fetch_word", checked_cnt, "alu_op", ALU_ADD, i_alu_op);
	endtask

	// ==========================================================
	// close one fetch-to-fetch window
	// ==========================================================
	task automatic close_profile();
		exp_entry_t e;
		string      name;
		if (exp_q.size() == 0) begin
			$display("instruction %0d finished but no expected profile was queued", checked_cnt);
			protocol_cnt++;
		end
		else begin
			e    = exp_q.pop_front();  // oldest issue first
			name = test_name(e.test);
			compare_field(name, checked_cnt, "cycles", int'(e.cycles), cur_cycles);
			compare_field(name, checked_cnt, "reg_write", int'(e.reg_w), cur_reg_w);
			compare_field(name, checked_cnt, "ccr_update", int'(e.ccr), cur_ccr);
			compare_field(name, checked_cnt, "mem_write", int'(e.mem_w), cur_mem_w);
			checked_cnt++;
		end
	endtask

	// ==========================================================
	// per cycle watch
	// ==========================================================
	always @(posedge clk) begin
		if (reset !== 1'b1) begin
			reset_cycles++;
			since_reset = 0;
			active      = 1'b0;  // window restarts at first fetch
			if (reset_cycles > 1 && enables !== 5'b0) begin  // first edge is before st_reset
				$display("control enable high during reset, enables %b", enables);
				protocol_cnt++;
			end
			if (reset_cycles > 1) begin
				compare_field("reset_state", checked_cnt, "state", ST_RESET, i_state);
			end
		end
		else begin
			if (since_reset < 3) begin
				since_reset++;
			end
			if (since_reset == 1 && enables !== 5'b0) begin
				$display("control enable high in first cycle after reset, enables %b", enables);
				protocol_cnt++;
			end
			if (since_reset == 2 && i_ir_write !== 1'b1) begin
				$display("no fetch in second cycle after reset");
				protocol_cnt++;
			end
			if (i_mem_read && i_mem_write) begin
				$display("mem_read and mem_write both high in %s", i_state.name());
				protocol_cnt++;
			end
			// ir write marks fetch and nothing else
			compare_field("fetch_state", checked_cnt, "ir_write",
				int'(i_state == ST_FETCH), int'(i_ir_write));
			if (i_exp_push) begin
				exp_q.push_back({i_exp_test, i_exp_cycles, i_exp_reg_w, i_exp_ccr, i_exp_mem_w});
			end
			if (i_ir_write) begin
				if (active) begin
					close_profile();  // previous instruction done
				end
				check_fetch_word();
				active     = 1'b1;
				cur_cycles = 1;  // fetch cycle counts
				cur_reg_w  = i_reg_write ? 1 : 0;
				cur_ccr    = i_ccr_update ? 1 : 0;
				cur_mem_w  = i_mem_write ? 1 : 0;
			end
			else if (active) begin
				cur_cycles++;
				if (i_reg_write) cur_reg_w++;
				if (i_ccr_update) cur_ccr++;
				if (i_mem_write) cur_mem_w++;
			end
		end
	end

endmodule

`default_nettype wire

//--- risc_controller.sv
`timescale 1ns/1ns
`default_nettype none

module risc_controller import ctrl_pkg::*; (
	input  wire              clk,
	input  wire              reset,         // sync, active low
	input  wire instr_u      i_instr,       // instruction register
	input  wire              i_carry,       // ccr flags
	input  wire              i_zero,
	output wire ctrl_state_e o_state,
	output wire              o_mem_read,
	output wire              o_mem_write,
	output wire              o_reg_write,
	output wire              o_ir_write,
	output wire              o_ccr_update,
	output wire              o_alu_src_a,
	output wire pc_src_e     o_pc_src,
	output wire alu_b_src_e  o_alu_b_src,
	output wire reg_dst_e    o_reg_dst,
	output wire wb_src_e     o_wb_src,
	output wire addr_src_e   o_addr_src,
	output wire flag_src_e   o_flag_src,
	output wire alu_op_e     o_alu_op
);

	wire instr_class_e instr_class;  // decoder to sequencer

	// ==========================================================
	// decode, sequence, drive
	// ==========================================================
	instr_decoder instr_decoder_i (
		.i_instr       (i_instr),
		.i_carry       (i_carry),
		.i_zero        (i_zero),
		.o_instr_class (instr_class)
	);

	state_sequencer state_sequencer_i (
		.clk           (clk),
		.reset         (reset),
		.i_zero        (i_zero),       // beq outcome
		.i_instr_class (instr_class),
		.o_state       (o_state)
	);

	control_word_gen control_word_gen_i (
		.i_state      (o_state),  // control word follows state only
		.o_mem_read   (o_mem_read),
		.o_mem_write  (o_mem_write),
		.o_reg_write  (o_reg_write),
		.o_ir_write   (o_ir_write),
		.o_ccr_update (o_ccr_update),
		.o_alu_src_a  (o_alu_src_a),
		.o_pc_src     (o_pc_src),
		.o_alu_b_src  (o_alu_b_src),
		.o_reg_dst    (o_reg_dst),
		.o_wb_src     (o_wb_src),
		.o_addr_src   (o_addr_src),
		.o_flag_src   (o_flag_src),
		.o_alu_op     (o_alu_op)
	);

endmodule

`default_nettype wire

//--- control_word_gen.sv
`timescale 1ns/1ns
`default_nettype none

module control_word_gen import ctrl_pkg::*; (
	input  wire ctrl_state_e i_state,
	output logic       o_mem_read,
	output logic       o_mem_write,
	output logic       o_reg_write,
	output logic       o_ir_write,    // fetch marker
	output logic       o_ccr_update,
	output logic       o_alu_src_a,   // 1 selects pc
	output pc_src_e    o_pc_src,
	output alu_b_src_e o_alu_b_src,
	output reg_dst_e   o_reg_dst,
	output wb_src_e    o_wb_src,
	output addr_src_e  o_addr_src,
	output flag_src_e  o_flag_src,
	output alu_op_e    o_alu_op
);

	// ==========================================================
	// state to control word
	// ==========================================================
	always_comb begin
		// idle word, every enable low
		o_mem_read   = 1'b0;
		o_mem_write  = 1'b0;
		o_reg_write  = 1'b0;
		o_ir_write   = 1'b0;
		o_ccr_update = 1'b0;
		o_alu_src_a  = 1'b1;
		o_pc_src     = PC_SRC_ALU;
		o_alu_b_src  = ALU_B_ONE;
		o_reg_dst    = REG_DST_PC;
		o_wb_src     = WB_ALU;
		o_addr_src   = ADDR_PC;
		o_flag_src   = FLAG_NONE;
		o_alu_op     = ALU_ADD;
		case (i_state)
			ST_FETCH: begin
				o_mem_read  = 1'b1;  // instruction from pc
				o_reg_write = 1'b1;  // pc plus one into r7
				o_ir_write  = 1'b1;
			end
			ST_DECODE: begin
				o_pc_src = PC_SRC_RB;  // register read only
			end
			ST_ADD: begin
				o_pc_src = PC_SRC_KEEP;
				o_alu_src_a = 1'b0;  // ra
				o_alu_b_src = ALU_B_REG;
				o_reg_dst = REG_DST_RC;
				o_flag_src = FLAG_R_TYPE;
				o_ccr_update = 1'b1;  // carry and zero from sum
			end
			ST_ALU_WB, ST_NAND: begin
				o_pc_src = PC_SRC_KEEP;
				o_alu_src_a = (i_state == ST_NAND);  // nand keeps a at 1
				o_alu_b_src = ALU_B_REG;
				o_reg_dst = REG_DST_RC;
				o_reg_write = 1'b1;  // result into rc
				o_flag_src = FLAG_R_TYPE;
				o_alu_op = (i_state == ST_NAND) ? ALU_NAND : ALU_ADD;
			end
			ST_ADI: begin
				o_pc_src = PC_SRC_RB;
				o_alu_src_a = 1'b0;
				o_alu_b_src = ALU_B_IMM;  // imm6
				o_reg_dst = REG_DST_RA;
				o_reg_write = 1'b1;
				o_flag_src = FLAG_I_TYPE;
				o_ccr_update = 1'b1;
			end
			ST_LHI: begin
				o_mem_read = 1'b1;
				o_pc_src = PC_SRC_RB;
				o_alu_src_a = 1'b0;
				o_alu_b_src = ALU_B_REG;
				o_reg_dst = REG_DST_RA;
				o_reg_write = 1'b1;
				o_wb_src = WB_LHI;  // imm9 into upper bits
				o_alu_op = ALU_NAND;
			end
			ST_LW_ADDR, ST_SW_ADDR: begin
				o_mem_read = (i_state == ST_LW_ADDR);
				o_pc_src = PC_SRC_RB;
				o_alu_src_a = 1'b0;  // base register
				o_alu_b_src = ALU_B_IMM;  // offset
				o_flag_src = FLAG_I_TYPE;
				if (i_state == ST_LW_ADDR) begin
					o_reg_dst = REG_DST_RA;
					o_reg_write = 1'b1;
					o_wb_src = WB_MEM;
					o_addr_src = ADDR_ALU;
				end
				else begin
					o_wb_src = WB_LHI;  // no write back on sw
				end
			end
			ST_LOAD: begin
				o_pc_src = PC_SRC_KEEP;
				o_alu_src_a = 1'b0;
				o_alu_b_src = ALU_B_ZERO;
				o_reg_dst = REG_DST_RA;
				o_wb_src = WB_MEM;
				o_addr_src = ADDR_ALU;  // data address
				o_ccr_update = 1'b1;  // zero from loaded word
			end
			ST_STORE: begin
				o_mem_write = 1'b1;  // only write in the table
				o_pc_src = PC_SRC_RB;
				o_alu_src_a = 1'b0;
				o_alu_b_src = ALU_B_IMM;
				o_reg_dst = REG_DST_RA;
				o_wb_src = WB_MEM;
				o_addr_src = ADDR_ALU;
				o_flag_src = FLAG_I_TYPE;
			end
			ST_BR_CMP, ST_BR_CHECK: begin
				o_pc_src = PC_SRC_RB;
				o_alu_src_a = 1'b0;
				o_alu_b_src = ALU_B_REG;  // ra minus rb
				o_wb_src = WB_MEM;
				o_flag_src = FLAG_I_TYPE;
				o_alu_op = ALU_SUB;
				o_ccr_update = (i_state == ST_BR_CMP);  // zero latched once
			end
			ST_BR_TAKE, ST_JAL_TARGET: begin
				o_alu_b_src = ALU_B_IMM;  // pc plus offset
				o_reg_write = 1'b1;
				o_flag_src = FLAG_I_TYPE;
			end
			ST_JMP_LINK: begin
				o_alu_b_src = ALU_B_ZERO;  // pc passes through
				o_reg_dst = REG_DST_RA;  // link register
				o_reg_write = 1'b1;
				o_flag_src = FLAG_I_TYPE;
			end
			ST_JLR_TARGET: begin
				o_pc_src = PC_SRC_RB;  // jump to rb
				o_alu_b_src = ALU_B_ZERO;
				o_reg_write = 1'b1;
			end
			default: begin
				o_pc_src = PC_SRC_ALU;  // reset keeps idle word
			end
		endcase
	end

endmodule

`default_nettype wire

//--- state_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module state_sequencer import ctrl_pkg::*; (
	input  wire          clk,
	input  wire          reset,          // sync, active low
	input  wire          i_zero,         // ccr zero for beq
	input  wire instr_class_e i_instr_class,  // from decoder
	output ctrl_state_e  o_state         // current state
);

	ctrl_state_e state;       // state register
	ctrl_state_e next_state;  // comb next state

	assign o_state = state;

	// ==========================================================
	// state register
	// ==========================================================
	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= ST_RESET;  // held while reset low
		end
		else begin
			state <= next_state;  // one transition per edge
		end
	end

	// ==========================================================
	// next state
	// ==========================================================
	always_comb begin
		next_state = ST_FETCH;  // most paths end in fetch
		case (state)
			ST_RESET:  next_state = ST_FETCH;
			ST_FETCH:  next_state = ST_DECODE;
			ST_DECODE: begin
				case (i_instr_class)
					CLS_ADD:           next_state = ST_ADD;
					CLS_NAND:          next_state = ST_NAND;
					CLS_ADI:           next_state = ST_ADI;
					CLS_LHI:           next_state = ST_LHI;
					CLS_LW:            next_state = ST_LW_ADDR;
					CLS_SW:            next_state = ST_SW_ADDR;
					CLS_BEQ:           next_state = ST_BR_CMP;
					CLS_JAL, CLS_JLR:  next_state = ST_JMP_LINK;  // shared link step
					default:           next_state = ST_FETCH;     // skip
				endcase
			end
			ST_ADD:      next_state = ST_ALU_WB;  // result written next
			ST_LW_ADDR:  next_state = ST_LOAD;
			ST_SW_ADDR:  next_state = ST_STORE;
			ST_BR_CMP:   next_state = ST_BR_CHECK;
			ST_BR_CHECK: begin
				if (i_zero) begin
					next_state = ST_BR_TAKE;  // operands equal
				end
				else begin
					next_state = ST_FETCH;
				end
			end
			ST_JMP_LINK: begin
				if (i_instr_class == CLS_JLR) begin
					next_state = ST_JLR_TARGET;  // target from rb
				end
				else begin
					next_state = ST_JAL_TARGET;  // pc relative target
				end
			end
			default: next_state = ST_FETCH;  // one cycle tails
		endcase
	end

	// ==========================================================
	// checks
	// ==========================================================
	a_jump_class_held : assert property (@(posedge clk) disable iff (!reset)
		(state == ST_JMP_LINK) |-> (i_instr_class inside {CLS_JAL, CLS_JLR}))
		else $error("instruction word changed before the jump target was chosen");

	a_beq_class_held : assert property (@(posedge clk) disable iff (!reset)
		(state inside {ST_BR_CMP, ST_BR_CHECK}) |-> (i_instr_class == CLS_BEQ))
		else $error("instruction word changed during the branch compare");

endmodule

`default_nettype wire

//--- instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder import ctrl_pkg::*; (
	input  wire instr_u  i_instr,       // ir value, held from fetch to fetch
	input  wire          i_carry,       // ccr carry flag
	input  wire          i_zero,        // ccr zero flag
	output instr_class_e o_instr_class  // to sequencer, combinational
);

	opcode_e      opcode;     // same bits in every layout
	logic [1:0]   cz;         // condition field of register layout
	logic         cond_ok;    // alu op allowed to run
	instr_class_e alu_class;  // add or nand group

	assign opcode = i_instr.r_fields.opcode;
	assign cz     = i_instr.r_fields.cz;

	// ==========================================================
	// condition check for adc adz ndc ndz
	// ==========================================================
	always_comb begin
		case (cz)
			2'b00:   cond_ok = 1'b1;     // plain add or ndu
			2'b10:   cond_ok = i_carry;  // adc or ndc
			2'b01:   cond_ok = i_zero;   // adz or ndz
			default: cond_ok = 1'b0;     // 11 never runs
		endcase
	end

	assign alu_class = (opcode == OP_NDU) ? CLS_NAND : CLS_ADD;

	// ==========================================================
	// opcode to class
	// ==========================================================
	always_comb begin
		o_instr_class = CLS_SKIP;  // unknown opcodes just refetch
		case (opcode)
			OP_ADD, OP_NDU: begin
				if (cond_ok) begin
					o_instr_class = alu_class;
				end
				else begin
					o_instr_class = CLS_SKIP;  // condition failed
				end
			end
			OP_ADI: o_instr_class = CLS_ADI;
			OP_LHI: o_instr_class = CLS_LHI;
			OP_LW:  o_instr_class = CLS_LW;
			OP_SW:  o_instr_class = CLS_SW;
			OP_BEQ: o_instr_class = CLS_BEQ;  // zero tested later in br check
			OP_JAL: o_instr_class = CLS_JAL;
			OP_JLR: o_instr_class = CLS_JLR;  // split from jal here only
			default: o_instr_class = CLS_SKIP;
		endcase
	end

endmodule

`default_nettype wire

//--- ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	`include "ctrl_settings.svh"

	// ==========================================================
	// instruction word
	// ==========================================================
	typedef enum logic [`OPCODE_W-1:0] {
		OP_ADD = 4'b0000,  // also adc and adz
		OP_ADI = 4'b0001,
		OP_NDU = 4'b0010,  // also ndc and ndz
		OP_LHI = 4'b0011,
		OP_LW  = 4'b0100,
		OP_SW  = 4'b0101,
		OP_JAL = 4'b1000,
		OP_JLR = 4'b1001,
		OP_BEQ = 4'b1100
	} opcode_e;

	typedef struct packed {
		opcode_e                 opcode;
		logic [`REG_IDX_W-1:0]   ra;
		logic [`REG_IDX_W-1:0]   rb;
		logic [`REG_IDX_W-1:0]   rc;  // destination of alu ops
		logic [`INSTR_W-`OPCODE_W-3*`REG_IDX_W-3:0] spare;  // unused bit
		logic [1:0]              cz;  // condition on carry or zero
	} r_fields_t;

	typedef struct packed {
		opcode_e                 opcode;
		logic [`REG_IDX_W-1:0]   ra;
		logic [`REG_IDX_W-1:0]   rb;
		logic [`IMM6_W-1:0]      imm6;  // sign extended in datapath
	} i_fields_t;

	typedef struct packed {
		opcode_e                 opcode;
		logic [`REG_IDX_W-1:0]   ra;
		logic [`IMM9_W-1:0]      imm9;  // jal offset or lhi value
	} j_fields_t;

	typedef union packed {
		r_fields_t r_fields;  // add and nand group
		i_fields_t i_fields;  // adi lw sw beq jlr
		j_fields_t j_fields;  // lhi jal
	} instr_u;

	// ==========================================================
	// controller internals
	// ==========================================================
	typedef enum logic [3:0] {
		CLS_ADD, CLS_NAND, CLS_ADI, CLS_LHI, CLS_LW,
		CLS_SW, CLS_BEQ, CLS_JAL, CLS_JLR,
		CLS_SKIP  // condition failed or unknown opcode
	} instr_class_e;

	typedef enum logic [4:0] {
		ST_RESET, ST_FETCH, ST_DECODE,
		ST_ADD, ST_ALU_WB, ST_NAND, ST_ADI, ST_LHI,
		ST_LW_ADDR, ST_LOAD, ST_SW_ADDR, ST_STORE,
		ST_BR_CMP, ST_BR_CHECK, ST_BR_TAKE,
		ST_JMP_LINK, ST_JAL_TARGET, ST_JLR_TARGET  // keep last
	} ctrl_state_e;

	// ==========================================================
	// datapath select codes
	// ==========================================================
	typedef enum logic [`SEL_W-1:0] {
		PC_SRC_RB   = 2'b00,  // register b into pc
		PC_SRC_KEEP = 2'b10,  // pc untouched
		PC_SRC_ALU  = 2'b11   // alu result into pc
	} pc_src_e;

	typedef enum logic [`SEL_W-1:0] {
		ALU_B_REG  = 2'b00,  // register b
		ALU_B_IMM  = 2'b01,  // extended immediate
		ALU_B_ZERO = 2'b10,  // pass a through
		ALU_B_ONE  = 2'b11   // pc increment
	} alu_b_src_e;

	typedef enum logic [`SEL_W-1:0] {
		REG_DST_RC = 2'b00,
		REG_DST_RA = 2'b01,
		REG_DST_PC = 2'b10   // r7
	} reg_dst_e;

	typedef enum logic [`SEL_W-1:0] {
		WB_MEM = 2'b00,  // memory data register
		WB_ALU = 2'b10,  // alu out
		WB_LHI = 2'b11   // imm9 shifted up
	} wb_src_e;

	typedef enum logic [`SEL_W-1:0] {
		ADDR_PC  = 2'b00,  // instruction fetch
		ADDR_ALU = 2'b11   // computed data address
	} addr_src_e;

	typedef enum logic [`SEL_W-1:0] {
		FLAG_NONE   = 2'b00,
		FLAG_R_TYPE = 2'b01,  // flags from register alu op
		FLAG_I_TYPE = 2'b11   // flags from immediate alu op
	} flag_src_e;

	typedef enum logic [`SEL_W-1:0] {
		ALU_ADD  = 2'b00,
		ALU_SUB  = 2'b01,  // beq compare
		ALU_NAND = 2'b10
	} alu_op_e;

endpackage

`default_nettype wire

//--- ctrl_settings.svh
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// instruction word layout
`define INSTR_W    16  // full instruction register
`define OPCODE_W   4   // top nibble selects the instruction
`define REG_IDX_W  3   // eight registers with r7 as pc
`define IMM6_W     6   // immediate of the i layout
`define IMM9_W     9   // immediate of the j layout and lhi

// datapath select lines
`define SEL_W      2   // every mux select code

`endif
